// File: lane_execute.sv
`timescale 1ns/1ps
`default_nettype none

module lane_execute #(
	parameter int NUM_OC = 2
) (
	input wire clk,
	input wire rst,
	input wire [NUM_OC-1:0] rdy,
	input wire oc_pkg::issue_ctrl_t [NUM_OC-1:0] ctrl,
	input wire oc_pkg::vreg_t [NUM_OC-1:0] op0,
	input wire oc_pkg::vreg_t [NUM_OC-1:0] op1,
	output logic [NUM_OC-1:0] read,
	output oc_pkg::exec_pkt_t exec
);
	import oc_pkg::*;

	int sel;
	issue_ctrl_t sel_ctrl;
	vreg_t result;

	function automatic lane_word_t alu(alu_op_e op, lane_word_t a, lane_word_t b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			alu_shl: return a << b[4:0];
			alu_shr: return a >> b[4:0];	// logical
			alu_min: return ($signed(a) < $signed(b)) ? a : b;	// signed compare
			default: return a;
		endcase
	endfunction

	always_comb
	begin
		sel = 0;
		read = '0;
		for (int i = NUM_OC-1; i >= 0; i--)
		begin
			if (rdy[i])
				sel = i;
		end
		if (|rdy)
			read[sel] = 1'b1;
	end

	assign sel_ctrl = ctrl[sel];

	always_comb
	begin
		for (int l = 0; l < num_lanes; l++)
			result[l*lane_w +: lane_w] = alu(sel_ctrl.op, op0[sel][l*lane_w +: lane_w],
				op1[sel][l*lane_w +: lane_w]);
	end

	always_ff @(posedge clk)
	begin
		exec.warp <= sel_ctrl.warp;
		exec.dst <= sel_ctrl.dst;
		exec.data <= result;
		if (!rst)
			exec.valid <= 1'b0;
		else
			exec.valid <= |rdy;
	end

endmodule

`default_nettype wire

// File: oc_pkg.sv
`default_nettype none

package oc_pkg;

	localparam int num_lanes = 8;
	localparam int lane_w = 32;
	localparam int num_banks = 4;
	localparam int bank_rows = 64;

	typedef logic [lane_w-1:0] lane_word_t;
	typedef logic [num_lanes*lane_w-1:0] vreg_t;
	typedef logic [4:0] reg_id_t;
	typedef logic [2:0] warp_id_t;
	typedef logic [1:0] bank_id_t;
	typedef logic [5:0] row_t;
	typedef logic [2:0] oc_tag_t;	// {collector id, slot}

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or = 4'd3,
		alu_xor = 4'd4,
		alu_shl = 4'd5,
		alu_shr = 4'd6,
		alu_min = 4'd7
	} alu_op_e;

	typedef struct packed {
		logic [3:0] op;
		warp_id_t warp;
		reg_id_t dst;
		reg_id_t src1;
		reg_id_t src2;
		logic imm_valid;
		logic [8:0] imm;
	} instr_t;

	typedef struct packed {
		alu_op_e op;
		warp_id_t warp;
		reg_id_t dst;
		reg_id_t src1;
		reg_id_t src2;
		logic imm_valid;
		lane_word_t imm;	// already sign extended
	} issue_ctrl_t;

	typedef struct packed {
		logic valid;
		bank_id_t bank;
		row_t row;
		oc_tag_t tag;
	} bank_req_t;

	typedef struct packed {
		logic vld;
		oc_tag_t tag;
		vreg_t data;
	} bank_reply_t;

	typedef struct packed {
		logic valid;
		warp_id_t warp;
		reg_id_t dst;
		vreg_t data;
	} exec_pkt_t;

	typedef struct packed {
		logic valid;
		warp_id_t warp;
		reg_id_t rid;
		vreg_t data;
	} load_req_t;

	function automatic bank_id_t bank_of(reg_id_t r);
		return r[1:0];
	endfunction

	function automatic row_t row_of(warp_id_t w, reg_id_t r);
		return {w, r[4:2]};
	endfunction

endpackage

`default_nettype wire

// File: operand_collector.sv
`timescale 1ns/1ps
`default_nettype none

module operand_collector #(
	parameter int ocid = 0
) (
	input wire clk,
	input wire rst,
	input wire we,
	input wire oc_pkg::issue_ctrl_t ctrl,
	input wire oc_pkg::bank_reply_t [oc_pkg::num_banks-1:0] reply,
	input wire [oc_pkg::num_banks-1:0] same,
	input wire read,
	output oc_pkg::bank_req_t req0,
	output oc_pkg::bank_req_t req1,
	output logic busy,
	output logic rdy,
	output oc_pkg::issue_ctrl_t held_ctrl,
	output oc_pkg::vreg_t op0,
	output oc_pkg::vreg_t op1
);
	import oc_pkg::*;

	localparam oc_tag_t tag0 = oc_tag_t'(2*ocid);
	localparam oc_tag_t tag1 = oc_tag_t'(2*ocid + 1);

	logic pend0;
	logic pend1;
	bank_id_t bank0;
	bank_id_t bank1;
	logic hit0;
	logic hit1;

	assign bank0 = bank_of(held_ctrl.src1);
	assign bank1 = bank_of(held_ctrl.src2);

	assign req0 = '{
		valid: pend0,
		bank: bank0,
		row: row_of(held_ctrl.warp, held_ctrl.src1),
		tag: tag0
	};
	assign req1 = '{
		valid: pend1,
		bank: bank1,
		row: row_of(held_ctrl.warp, held_ctrl.src2),
		tag: tag1
	};

	assign hit0 = pend0 && reply[bank0].vld && (reply[bank0].tag == tag0);

	// slot 1 rides along on slot 0 reply when the bank flags same row
	assign hit1 = pend1 && ((reply[bank1].vld && (reply[bank1].tag == tag1)) ||
		(hit0 && same[bank0]));

	assign rdy = busy && !pend0 && !pend1;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			busy <= 1'b0;
			pend0 <= 1'b0;
			pend1 <= 1'b0;
		end
		else if (we)
		begin
			busy <= 1'b1;
			pend0 <= 1'b1;
			pend1 <= !ctrl.imm_valid;	// imm fills slot 1 now
		end
		else if (read)
		begin
			busy <= 1'b0;
			pend0 <= 1'b0;
			pend1 <= 1'b0;
		end
		else
		begin
			if (hit0)
				pend0 <= 1'b0;
			if (hit1)
				pend1 <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (we)
		begin
			held_ctrl <= ctrl;
			if (ctrl.imm_valid)
				op1 <= {num_lanes{ctrl.imm}};	// same imm in every lane
		end
		else
		begin
			if (hit0)
				op0 <= reply[bank0].data;
			if (hit1)
				op1 <= reply[bank1].data;
		end
	end

endmodule

`default_nettype wire

// File: operand_decode.sv
`timescale 1ns/1ps
`default_nettype none

module operand_decode #(
	parameter int NUM_OC = 2
) (
	input wire clk,
	input wire rst,
	input wire issue,
	input wire oc_pkg::instr_t instr,
	input wire [NUM_OC-1:0] busy,
	output oc_pkg::issue_ctrl_t issue_ctrl,
	output logic [NUM_OC-1:0] oc_we,
	output logic issue_ready
);
	import oc_pkg::*;

	logic armed;	// busy only meaningful once reset has been applied
	logic [NUM_OC-1:0] free;
	logic [NUM_OC-1:0] pick;

	always_ff @(posedge clk)
	begin
		if (!rst)
			armed <= 1'b0;
		else
			armed <= 1'b1;
	end

	assign free = armed ? ~busy : '0;

	always_comb
	begin
		pick = '0;
		for (int i = NUM_OC-1; i >= 0; i--)
		begin
			if (free[i])
			begin
				pick = '0;
				pick[i] = 1'b1;	// lowest free wins
			end
		end
	end

	assign issue_ready = |free;
	assign oc_we = issue ? pick : '0;

	always_comb
	begin
		issue_ctrl.op = alu_op_e'(instr.op);
		issue_ctrl.warp = instr.warp;
		issue_ctrl.dst = instr.dst;
		issue_ctrl.src1 = instr.src1;
		issue_ctrl.src2 = instr.src2;
		issue_ctrl.imm_valid = instr.imm_valid;
		issue_ctrl.imm = {{(lane_w-9){instr.imm[8]}}, instr.imm};
	end

endmodule

`default_nettype wire

// File: operand_tb.sv
`timescale 1ns/1ps
`default_nettype none

module operand_tb;
	import oc_pkg::*;

	localparam int clk_period = 100;
	localparam int num_oc = 2;
	localparam int max_rows = 32;
	localparam int load_cycles = 8*32 + 1;

	typedef struct packed {
		instr_t instr;
		logic wait_wb;	// hold next row until this one is written back
	} test_row_t;

	typedef struct packed {
		logic [7:0] row;
		warp_id_t warp;
		reg_id_t dst;
		vreg_t data;
	} expect_t;

	logic clk;
	logic rst;
	logic issue;
	instr_t instr;
	load_req_t load;
	logic issue_ready;
	exec_pkt_t wb_out;

	test_row_t rows [max_rows];
	expect_t pending [$];
	vreg_t model [8][32];
	logic [31:0] lfsr_state;
	int n_rows;
	int issued_cnt;
	int done_cnt;
	int pass_cnt;
	int fail_cnt;
	int err_cnt;
	int stall_cycles;

	operand_top #(.NUM_OC(num_oc)) dut0 (
		.clk, .rst, .issue, .instr, .load, .issue_ready, .wb_out
	);

	always #(clk_period/2) clk = ~clk;

	// taps of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_bits(int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic lane_word_t ref_lane(logic [3:0] op, lane_word_t a, lane_word_t b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_and: return a & b;
			alu_or: return a | b;
			alu_xor: return a ^ b;
			alu_shl: return a << b[4:0];
			alu_shr: return a >> b[4:0];
			alu_min: return ($signed(a) < $signed(b)) ? a : b;
			default: return a;	// unknown op passes src1
		endcase
	endfunction

	function automatic vreg_t expected_value(instr_t in);
		vreg_t a;
		vreg_t b;
		vreg_t r;
		a = model[in.warp][in.src1];
		if (in.imm_valid)
			b = {num_lanes{{{(lane_w-9){in.imm[8]}}, in.imm}}};
		else
			b = model[in.warp][in.src2];
		for (int l = 0; l < num_lanes; l++)
			r[l*lane_w +: lane_w] = ref_lane(in.op, a[l*lane_w +: lane_w], b[l*lane_w +: lane_w]);
		return r;
	endfunction

	task automatic add_row(logic [3:0] op, warp_id_t w, reg_id_t d, reg_id_t s1, reg_id_t s2,
		logic iv, logic [8:0] imm, logic wait_wb);
		rows[n_rows].instr = {op, w, d, s1, s2, iv, imm};
		rows[n_rows].wait_wb = wait_wb;
		n_rows++;
	endtask

	task automatic build_table();
		add_row(alu_add, 3'd0, 5'd20, 5'd1, 5'd2, 1'b0, 9'd0, 1'b1);	// every op
		add_row(alu_sub, 3'd0, 5'd21, 5'd3, 5'd4, 1'b0, 9'd0, 1'b1);
		add_row(alu_and, 3'd1, 5'd20, 5'd5, 5'd6, 1'b0, 9'd0, 1'b1);
		add_row(alu_or, 3'd1, 5'd21, 5'd7, 5'd8, 1'b0, 9'd0, 1'b1);
		add_row(alu_xor, 3'd2, 5'd20, 5'd9, 5'd10, 1'b0, 9'd0, 1'b1);
		add_row(alu_shl, 3'd2, 5'd21, 5'd11, 5'd12, 1'b0, 9'd0, 1'b1);
		add_row(alu_shr, 3'd3, 5'd20, 5'd13, 5'd14, 1'b0, 9'd0, 1'b1);
		add_row(alu_min, 3'd3, 5'd21, 5'd15, 5'd16, 1'b0, 9'd0, 1'b1);
		add_row(4'd9, 3'd4, 5'd20, 5'd1, 5'd2, 1'b0, 9'd0, 1'b1);	// passthrough
		add_row(alu_add, 3'd4, 5'd21, 5'd3, 5'd0, 1'b1, 9'h1fb, 1'b1);	// imm -5
		add_row(alu_xor, 3'd5, 5'd20, 5'd4, 5'd0, 1'b1, 9'h0ff, 1'b1);
		add_row(alu_add, 3'd5, 5'd21, 5'd6, 5'd6, 1'b0, 9'd0, 1'b1);	// same register
		add_row(alu_min, 3'd6, 5'd22, 5'd10, 5'd10, 1'b0, 9'd0, 1'b1);
		add_row(alu_add, 3'd0, 5'd24, 5'd1, 5'd5, 1'b0, 9'd0, 1'b0);	// bank 1 conflict
		add_row(alu_sub, 3'd1, 5'd24, 5'd9, 5'd13, 1'b0, 9'd0, 1'b1);
		add_row(alu_add, 3'd0, 5'd25, 5'd20, 5'd21, 1'b0, 9'd0, 1'b1);	// reads results
		add_row(alu_xor, 3'd2, 5'd26, 5'd20, 5'd21, 1'b0, 9'd0, 1'b1);
		add_row(alu_add, 3'd7, 5'd10, 5'd1, 5'd2, 1'b0, 9'd0, 1'b0);	// fills both collectors
		add_row(alu_or, 3'd7, 5'd11, 5'd3, 5'd4, 1'b0, 9'd0, 1'b0);
		add_row(alu_and, 3'd7, 5'd12, 5'd5, 5'd6, 1'b0, 9'd0, 1'b1);
	endtask

	task automatic load_registers();
		vreg_t v;
		for (int w = 0; w < 8; w++)
		begin
			for (int r = 0; r < 32; r++)
			begin
				@(negedge clk);
				for (int l = 0; l < num_lanes; l++)
					v[l*lane_w +: lane_w] = lfsr_bits(lane_w);
				model[w][r] = v;
				load.valid = 1'b1;
				load.warp = warp_id_t'(w);
				load.rid = reg_id_t'(r);
				load.data = v;
			end
		end
		@(negedge clk);
		load = '0;
	endtask

	task automatic issue_row(int i);
		while (!issue_ready)
		begin
			// fewer outstanding instructions than collectors means one is free
			assert (issued_cnt - done_cnt >= num_oc)
			else
			begin
				$display("ERROR at %0t: issue_ready low with %0d instructions in flight",
					$time, issued_cnt - done_cnt);
				err_cnt++;
			end
			stall_cycles++;
			@(negedge clk);
		end
		pending.push_back('{row: 8'(i), warp: rows[i].instr.warp, dst: rows[i].instr.dst,
			data: expected_value(rows[i].instr)});
		issue = 1'b1;
		instr = rows[i].instr;
		issued_cnt++;
		@(negedge clk);
		issue = 1'b0;
	endtask

	task automatic wait_idle();
		wait (done_cnt == issued_cnt);
		@(negedge clk);
	endtask

	task automatic check_result();
		int idx;
		int bad;
		expect_t e;
		idx = -1;
		bad = 0;
		foreach (pending[k])
		begin
			if (idx < 0 && pending[k].warp == wb_out.warp && pending[k].dst == wb_out.dst)
				idx = k;
		end
		assert (idx >= 0)
		else
		begin
			$display("write-back for warp %0d r%0d at %0t matches no instruction in flight",
				wb_out.warp, wb_out.dst, $time);
			err_cnt++;
		end
		if (idx >= 0)
		begin
			e = pending[idx];
			pending.delete(idx);
			for (int l = 0; l < num_lanes; l++)
			begin
				assert (wb_out.data[l*lane_w +: lane_w] == e.data[l*lane_w +: lane_w])
				else
				begin
					$display("ERROR at %0t: row %0d lane %0d got %h expected %h", $time, e.row, l,
						wb_out.data[l*lane_w +: lane_w], e.data[l*lane_w +: lane_w]);
					bad++;
				end
			end
			model[e.warp][e.dst] = e.data;
			err_cnt += bad;
			if (bad == 0)
				pass_cnt++;
			else
				fail_cnt++;
			$display("row %0d warp %0d r%0d: %s", e.row, e.warp, e.dst, (bad == 0) ? "pass" : "fail");
			done_cnt++;
		end
	endtask

	always @(negedge clk)
	begin
		if (rst && wb_out.valid)
			check_result();
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b0;
		issue = 1'b0;
		instr = '0;
		load = '0;
		lfsr_state = 32'h2d45;
		n_rows = 0;
		issued_cnt = 0;
		done_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		err_cnt = 0;
		stall_cycles = 0;
		build_table();
		repeat (3) @(negedge clk);
		rst = 1'b1;
		load_registers();
		for (int i = 0; i < n_rows; i++)
		begin
			issue_row(i);
			if (rows[i].wait_wb)
				wait_idle();
		end
		wait_idle();
		assert (stall_cycles > 0)
		else
		begin
			$display("issue_ready never dropped while all collectors were busy");
			err_cnt++;
		end
		$display("tests run %0d, passed %0d, failed %0d, errors %0d",
			n_rows, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0 && fail_cnt == 0 && pass_cnt == n_rows)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial
	begin
		int limit;
		#1;
		limit = 3 + load_cycles + n_rows*40;	// reset, loads, then 40 cycles a row
		#(limit*clk_period);
		$display("run timed out after %0d cycles, %0d of %0d results seen",
			limit, done_cnt, issued_cnt);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: operand_top.f
oc_pkg.sv
operand_decode.sv
register_banks.sv
operand_collector.sv
lane_execute.sv
result_writeback.sv
operand_top.sv
operand_tb.sv

// File: operand_top.sv
`timescale 1ns/1ps
`default_nettype none

module operand_top #(
	parameter int NUM_OC = 2
) (
	input wire clk,
	input wire rst,
	input wire issue,
	input wire oc_pkg::instr_t instr,
	input wire oc_pkg::load_req_t load,
	output wire issue_ready,
	output wire oc_pkg::exec_pkt_t wb_out
);
	import oc_pkg::*;

	wire issue_ctrl_t issue_ctrl;
	wire [NUM_OC-1:0] oc_we;
	wire [NUM_OC-1:0] busy;
	wire [NUM_OC-1:0] rdy;
	wire [NUM_OC-1:0] read;
	wire bank_req_t [2*NUM_OC-1:0] req;
	wire bank_reply_t [num_banks-1:0] reply;
	wire [num_banks-1:0] same;
	wire issue_ctrl_t [NUM_OC-1:0] held_ctrl;
	wire vreg_t [NUM_OC-1:0] op0;
	wire vreg_t [NUM_OC-1:0] op1;
	wire exec_pkt_t exec;
	wire load_req_t wb_wr;
	wire load_req_t bank_wr;

	assign bank_wr = load.valid ? load : wb_wr;	// host load first

	operand_decode #(.NUM_OC(NUM_OC)) dec0 (
		.clk, .rst, .issue, .instr, .busy,
		.issue_ctrl, .oc_we, .issue_ready
	);

	register_banks #(.NUM_OC(NUM_OC)) banks0 (
		.clk, .rst, .req, .wr(bank_wr), .reply, .same
	);

	for (genvar i = 0; i < NUM_OC; i++)
	begin : g_oc
		operand_collector #(.ocid(i)) oc (
			.clk, .rst,
			.we(oc_we[i]), .ctrl(issue_ctrl), .reply, .same, .read(read[i]),
			.req0(req[2*i]), .req1(req[2*i+1]),
			.busy(busy[i]), .rdy(rdy[i]),
			.held_ctrl(held_ctrl[i]), .op0(op0[i]), .op1(op1[i])
		);
	end

	lane_execute #(.NUM_OC(NUM_OC)) exe0 (
		.clk, .rst, .rdy, .ctrl(held_ctrl), .op0, .op1, .read, .exec
	);

	result_writeback wb0 (
		.clk, .rst, .exec, .wr(wb_wr), .wb_out
	);

endmodule

`default_nettype wire

// File: register_banks.sv
`timescale 1ns/1ps
`default_nettype none

module register_banks #(
	parameter int NUM_OC = 2
) (
	input wire clk,
	input wire rst,
	input wire oc_pkg::bank_req_t [2*NUM_OC-1:0] req,
	input wire oc_pkg::load_req_t wr,
	output oc_pkg::bank_reply_t [oc_pkg::num_banks-1:0] reply,
	output logic [oc_pkg::num_banks-1:0] same
);
	import oc_pkg::*;

	for (genvar b = 0; b < num_banks; b++)
	begin : g_bank
		vreg_t mem [bank_rows];
		logic wr_hit;
		logic grant;
		logic pair;
		int win;
		logic rep_vld;
		oc_tag_t rep_tag;
		vreg_t rep_data;
		logic same_q;

		assign wr_hit = wr.valid && (bank_of(wr.rid) == bank_id_t'(b));

		always_comb
		begin
			logic stale;
			grant = 1'b0;
			pair = 1'b0;
			win = 0;
			for (int i = 0; i < 2*NUM_OC; i++)
			begin
				// reply for this tag already on its way
				stale = rep_vld && ((req[i].tag == rep_tag) ||
					(same_q && req[i].tag == (rep_tag | oc_tag_t'(1))));
				if (req[i].valid && req[i].bank == bank_id_t'(b) && !stale &&
					(!grant || req[i].tag < req[win].tag))
				begin
					grant = 1'b1;
					win = i;
				end
			end
			for (int i = 0; i < 2*NUM_OC; i++)
			begin
				if (grant && !req[win].tag[0] && req[i].valid &&
					req[i].tag == (req[win].tag | oc_tag_t'(1)) &&
					req[i].bank == bank_id_t'(b) && req[i].row == req[win].row)
					pair = 1'b1;	// other slot, same register
			end
			if (wr_hit)
			begin
				grant = 1'b0;	// write owns the bank this cycle
				pair = 1'b0;
			end
		end

		always_ff @(posedge clk)
		begin
			if (wr_hit)
				mem[row_of(wr.warp, wr.rid)] <= wr.data;
		end

		always_ff @(posedge clk)
		begin
			if (grant)
			begin
				rep_tag <= req[win].tag;
				rep_data <= mem[req[win].row];
			end
			if (!rst)
			begin
				rep_vld <= 1'b0;
				same_q <= 1'b0;
			end
			else
			begin
				rep_vld <= grant;
				same_q <= pair;
			end
		end

		assign reply[b] = '{vld: rep_vld, tag: rep_tag, data: rep_data};
		assign same[b] = same_q;
	end

endmodule

`default_nettype wire

// File: result_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
	input wire clk,
	input wire rst,
	input wire oc_pkg::exec_pkt_t exec,
	output oc_pkg::load_req_t wr,
	output oc_pkg::exec_pkt_t wb_out
);
	import oc_pkg::*;

	exec_pkt_t wb_q;

	always_ff @(posedge clk)
	begin
		if (exec.valid)
		begin
			wb_q.warp <= exec.warp;
			wb_q.dst <= exec.dst;
			wb_q.data <= exec.data;
		end
		if (!rst)
			wb_q.valid <= 1'b0;
		else
			wb_q.valid <= exec.valid;	// one cycle pulse per result
	end

	// bank write and output port in the same cycle
	assign wr = '{
		valid: wb_q.valid,
		warp: wb_q.warp,
		rid: wb_q.dst,
		data: wb_q.data
	};

	assign wb_out = wb_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the operand collector testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module operand_tb -f operand_top.f \
	--Mdir obj_dir -o operand_sim > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/operand_sim > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test FAILED" "$sim_log"; then
	exit 1
fi
if ! grep -q "Test OK" "$sim_log"; then
	echo "simulation log holds no pass line"
	exit 1
fi
exit 0
